// File: design/board_macros.svh
// Board-wide size and identity constants, included by RTL and testbench sources
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// Reset conditioning, shortened to simulation scale
// System reset holds for 63 cycles
`define DEBOUNCE_W 6
// Peripheral reset released when MSB sets, after 16 cycles
`define PERIPH_RST_W 5

// LED pulse stretch length
`define LED_STRETCH_W 8

// CSR bus geometry
`define CSR_ADR_W 14
// Upper address bits selecting a bank
`define CSR_BANK_W 4
// System controller bank
`define SYSCTL_BANK 4'd1
`define DATA_W 32

// GPIO widths, 8 dip switches + 5 buttons in
`define GPIO_IN_W 13
// 2 LEDs, 5 button LEDs, 7 LCD pins out
`define GPIO_OUT_W 14

// Board identifier, ASCII "X401"
`define SYSTEM_ID 32'h58343031

`endif

// File: design/board_pkg.sv
// Board-level data types for GPIO words and the CSR data path, used by name from this package
`include "board_macros.svh"

package board_pkg;

	// GPIO input word
	// dip switches in the upper bits, buttons below
	typedef logic [`GPIO_IN_W-1:0] gpio_in_t;

	// GPIO output word
	// LEDs, button LEDs, then LCD control and data
	typedef logic [`GPIO_OUT_W-1:0] gpio_out_t;

	// Bus and CSR data word
	typedef logic [`DATA_W-1:0] csr_word_t;

endpackage

// File: design/csr_pkg.sv
// CSR bus types, bridge FSM states and system controller register map, used by scoped name
`include "board_macros.svh"

package csr_pkg;

	// CSR address, bank in the upper bits
	typedef logic [`CSR_ADR_W-1:0] csr_adr_t;

	// Bus to CSR bridge states
	typedef enum logic [1:0] {
		BR_IDLE      = 2'd0,
		BR_WRITE_ACK = 2'd1,
		BR_READ_WAIT = 2'd2,
		BR_READ_ACK  = 2'd3
	} bridge_state_t;

	// Register offsets inside the system controller bank
	typedef enum logic [9:0] {
		REG_GPIO_IN    = 10'd0,
		REG_GPIO_OUT   = 10'd1,
		REG_IRQ_EN     = 10'd2,
		REG_IRQ_PEND   = 10'd3,
		REG_SYSTEM_ID  = 10'd4,
		REG_HARD_RESET = 10'd5
	} csr_reg_t;

endpackage

// File: design/reset_gen.sv
// Reset generator, turns the reset button and software hard reset into system and peripheral resets
`include "board_macros.svh"

module reset_gen (
	input  logic sys_clk,
	input  logic reset_i,
	input  logic rst_btn_n_i,
	input  logic hard_reset_i,
	output logic sys_rst_o,
	output logic periph_rst_n_o
);

	logic                     btn_meta;
	logic                     btn_sync;
	logic                     reload;
	logic [`DEBOUNCE_W-1:0]   debounce_q;
	logic [`PERIPH_RST_W-1:0] periph_cnt_q;

	// Button is active low, rests high
	always_ff @(posedge sys_clk) begin
		if (reset_i) begin
			btn_meta <= 1'b1;
			btn_sync <= 1'b1;
		end else begin
			btn_meta <= rst_btn_n_i;
			btn_sync <= btn_meta;
		end
	end

	// Press or software request restarts the hold time
	assign reload = ~btn_sync | hard_reset_i;

	// Debounce down-counter, reset held while nonzero
	// reload also sets reset directly so it reacts on the same edge
	always_ff @(posedge sys_clk) begin
		if (reset_i) begin
			debounce_q <= '1;
			sys_rst_o  <= 1'b1;
		end else begin
			if (reload)
				debounce_q <= '1;
			else if (debounce_q != '0)
				debounce_q <= debounce_q - 1'b1;
			sys_rst_o <= reload | (debounce_q != '0);
		end
	end

	// Flash/PHY reset counter, stops once MSB sets
	// Restart only on a press seen outside system reset
	always_ff @(posedge sys_clk) begin
		if (reset_i)
			periph_cnt_q <= '0;
		else if (~btn_sync & ~sys_rst_o)
			periph_cnt_q <= '0;
		else if (~periph_cnt_q[`PERIPH_RST_W-1])
			periph_cnt_q <= periph_cnt_q + 1'b1;
	end

	assign periph_rst_n_o = periph_cnt_q[`PERIPH_RST_W-1];

	// Peripherals must be out of reset once the system has left it
	periph_before_sys: assert property (@(posedge sys_clk) disable iff (reset_i)
		(!sys_rst_o && $past(!sys_rst_o) && btn_sync) |-> periph_rst_n_o);

endmodule

// File: design/activity_led.sv
// Pulse stretcher, keeps an activity LED lit after a serial line goes low
`include "board_macros.svh"

module activity_led (
	input  logic sys_clk,
	input  logic reset_i,
	input  logic line_i,
	output logic led_o
);

	logic [`LED_STRETCH_W-1:0] stretch_q;

	// Any low bit (start bit, data zeros) retriggers the pulse
	always_ff @(posedge sys_clk) begin
		if (reset_i) begin
			stretch_q <= '0;
			led_o     <= 1'b0;
		end else begin
			if (!line_i)
				stretch_q <= '1;
			else if (stretch_q != '0)
				stretch_q <= stretch_q - 1'b1;
			// Registered LED drive
			led_o <= (stretch_q != '0);
		end
	end

endmodule

// File: design/csr_bridge.sv
// Bridges single bus transfers onto the CSR bus with fixed write and read acknowledge latency
module csr_bridge (
	input  logic                 sys_clk,
	input  logic                 reset_i,
	input  csr_pkg::csr_adr_t    wb_adr_i,
	input  board_pkg::csr_word_t wb_dat_i,
	output board_pkg::csr_word_t wb_dat_o,
	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	input  logic                 wb_we_i,
	output logic                 wb_ack_o,
	output csr_pkg::csr_adr_t    csr_a_o,
	output logic                 csr_we_o,
	output board_pkg::csr_word_t csr_dw_o,
	input  board_pkg::csr_word_t csr_dr_i
);

	csr_pkg::bridge_state_t state_q;
	logic                   phase_q;
	logic                   start;

	// New transfer only once the previous acknowledge has passed
	assign start = (state_q == csr_pkg::BR_IDLE) && wb_cyc_i && wb_stb_i && !wb_ack_o;

	// ---------------------------------------------------------------------
	// Control FSM
	// ---------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (reset_i) begin
			state_q  <= csr_pkg::BR_IDLE;
			phase_q  <= 1'b0;
			csr_we_o <= 1'b0;
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= 1'b0;
			case (state_q)
				csr_pkg::BR_IDLE: begin
					if (start)
						state_q <= wb_we_i ? csr_pkg::BR_WRITE_ACK : csr_pkg::BR_READ_WAIT;
				end
				// First phase strobes the write and the second acknowledges
				csr_pkg::BR_WRITE_ACK: begin
					if (!phase_q) begin
						csr_we_o <= 1'b1;
						phase_q  <= 1'b1;
					end else begin
						csr_we_o <= 1'b0;
						phase_q  <= 1'b0;
						wb_ack_o <= 1'b1;
						state_q  <= csr_pkg::BR_IDLE;
					end
				end
				// Slave registers its read data here
				csr_pkg::BR_READ_WAIT: state_q <= csr_pkg::BR_READ_ACK;
				// First phase captures data and the second acknowledges
				csr_pkg::BR_READ_ACK: begin
					if (!phase_q) begin
						phase_q <= 1'b1;
					end else begin
						phase_q  <= 1'b0;
						wb_ack_o <= 1'b1;
						state_q  <= csr_pkg::BR_IDLE;
					end
				end
				default: state_q <= csr_pkg::BR_IDLE;
			endcase
		end
	end

	// Address, write data and read data
	always_ff @(posedge sys_clk) begin
		if (start) begin
			csr_a_o  <= wb_adr_i;
			csr_dw_o <= wb_dat_i;
		end
		if (state_q == csr_pkg::BR_READ_ACK && !phase_q)
			wb_dat_o <= csr_dr_i;
	end

	// Acknowledge only answers a strobe the master still held
	ack_on_strobe: assert property (@(posedge sys_clk) disable iff (reset_i)
		wb_ack_o |-> $past(wb_cyc_i && wb_stb_i));

	// A CSR write only comes from a strobed bus write
	we_from_write: assert property (@(posedge sys_clk) disable iff (reset_i)
		csr_we_o |-> $past(wb_cyc_i && wb_stb_i && wb_we_i));

endmodule

// File: design/sysctl_gpio.sv
// System controller CSR bank with GPIO in/out, change interrupt, system ID and hard reset
`include "board_macros.svh"

module sysctl_gpio (
	input  logic                 sys_clk,
	input  logic                 reset_i,
	input  csr_pkg::csr_adr_t    csr_a_i,
	input  logic                 csr_we_i,
	input  board_pkg::csr_word_t csr_dw_i,
	output board_pkg::csr_word_t csr_dr_o,
	input  board_pkg::gpio_in_t  gpio_i,
	output board_pkg::gpio_out_t gpio_o,
	output logic                 gpio_irq_o,
	output logic                 hard_reset_o
);

	localparam int OFS_W   = `CSR_ADR_W - `CSR_BANK_W;
	localparam int IN_PAD  = `DATA_W - `GPIO_IN_W;
	localparam int OUT_PAD = `DATA_W - `GPIO_OUT_W;

	board_pkg::gpio_in_t gpio_meta;
	board_pkg::gpio_in_t gpio_sync;
	board_pkg::gpio_in_t gpio_prev;
	board_pkg::gpio_in_t irq_en_q;
	board_pkg::gpio_in_t irq_pend_q;
	board_pkg::gpio_in_t pend_clr;
	logic                bank_sel;
	csr_pkg::csr_reg_t   reg_sel;

	// Bank and register decode
	assign bank_sel = (csr_a_i[`CSR_ADR_W-1 -: `CSR_BANK_W] == `SYSCTL_BANK);
	assign reg_sel  = csr_pkg::csr_reg_t'(csr_a_i[OFS_W-1:0]);

	// Write 1 to clear pending bits
	assign pend_clr = (bank_sel && csr_we_i && reg_sel == csr_pkg::REG_IRQ_PEND) ?
		csr_dw_i[`GPIO_IN_W-1:0] : '0;

	assign gpio_irq_o = |irq_pend_q;

	// Two-stage input synchronizer
	always_ff @(posedge sys_clk) begin
		if (reset_i) begin
			gpio_meta <= '0;
			gpio_sync <= '0;
		end else begin
			gpio_meta <= gpio_i;
			gpio_sync <= gpio_meta;
		end
	end

	// ---------------------------------------------------------------------
	// Registers and interrupt
	// ---------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (reset_i) begin
			gpio_prev    <= '0;
			irq_en_q     <= '0;
			irq_pend_q   <= '0;
			gpio_o       <= '0;
			hard_reset_o <= 1'b0;
			csr_dr_o     <= '0;
		end else begin
			gpio_prev    <= gpio_sync;
			hard_reset_o <= 1'b0;
			// Edge on an enabled input wins over a clear
			irq_pend_q <= (irq_pend_q & ~pend_clr) | ((gpio_sync ^ gpio_prev) & irq_en_q);

			if (bank_sel && csr_we_i) begin
				case (reg_sel)
					csr_pkg::REG_GPIO_OUT:   gpio_o <= csr_dw_i[`GPIO_OUT_W-1:0];
					csr_pkg::REG_IRQ_EN:     irq_en_q <= csr_dw_i[`GPIO_IN_W-1:0];
					csr_pkg::REG_HARD_RESET: hard_reset_o <= 1'b1;
					default: ;
				endcase
			end

			// Read mux, zero outside this bank
			csr_dr_o <= '0;
			if (bank_sel) begin
				case (reg_sel)
					csr_pkg::REG_GPIO_IN:   csr_dr_o <= {{IN_PAD{1'b0}}, gpio_sync};
					csr_pkg::REG_GPIO_OUT:  csr_dr_o <= {{OUT_PAD{1'b0}}, gpio_o};
					csr_pkg::REG_IRQ_EN:    csr_dr_o <= {{IN_PAD{1'b0}}, irq_en_q};
					csr_pkg::REG_IRQ_PEND:  csr_dr_o <= {{IN_PAD{1'b0}}, irq_pend_q};
					csr_pkg::REG_SYSTEM_ID: csr_dr_o <= `SYSTEM_ID;
					default:                csr_dr_o <= '0;
				endcase
			end
		end
	end

	// Hard reset request is a single strobe into the reset generator
	hard_reset_pulse: assert property (@(posedge sys_clk) disable iff (reset_i)
		hard_reset_o |=> !hard_reset_o);

endmodule

// File: design/board_ctrl_top.sv
// Board housekeeping top level, connects resets, CSR bridge, system controller and LED pins
module board_ctrl_top (
	input  logic                 sys_clk,
	input  logic                 reset_i,
	input  logic                 rst_btn_n_i,
	input  csr_pkg::csr_adr_t    wb_adr_i,
	input  board_pkg::csr_word_t wb_dat_i,
	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	input  logic                 wb_we_i,
	output board_pkg::csr_word_t wb_dat_o,
	output logic                 wb_ack_o,
	input  logic [4:0]           btn_i,
	input  logic [7:0]           dipsw_i,
	input  logic                 uart_rxd_i,
	input  logic                 uart_txd_i,
	output logic [3:0]           led_o,
	output logic [4:0]           btnled_o,
	output logic                 lcd_e_o,
	output logic                 lcd_rs_o,
	output logic                 lcd_rw_o,
	output logic [3:0]           lcd_d_o,
	output logic                 gpio_irq_o,
	output logic                 sys_rst_o,
	output logic                 periph_rst_n_o
);

	logic                 hard_reset;
	logic                 csr_we;
	csr_pkg::csr_adr_t    csr_a;
	board_pkg::csr_word_t csr_dw;
	board_pkg::csr_word_t csr_dr;
	board_pkg::gpio_out_t gpio_out;
	logic                 tx_act;
	logic                 rx_act;

	// ---------------------------------------------------------------------
	// Reset and CSR path
	// ---------------------------------------------------------------------
	reset_gen u_reset_gen (
		.sys_clk        (sys_clk),
		.reset_i        (reset_i),
		.rst_btn_n_i    (rst_btn_n_i),
		.hard_reset_i   (hard_reset),
		.sys_rst_o      (sys_rst_o),
		.periph_rst_n_o (periph_rst_n_o)
	);

	csr_bridge u_csr_bridge (
		.sys_clk  (sys_clk),
		.reset_i  (sys_rst_o),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_we_i  (wb_we_i),
		.wb_ack_o (wb_ack_o),
		.csr_a_o  (csr_a),
		.csr_we_o (csr_we),
		.csr_dw_o (csr_dw),
		.csr_dr_i (csr_dr)
	);

	// Only CSR slave, read data goes straight back
	sysctl_gpio u_sysctl (
		.sys_clk      (sys_clk),
		.reset_i      (sys_rst_o),
		.csr_a_i      (csr_a),
		.csr_we_i     (csr_we),
		.csr_dw_i     (csr_dw),
		.csr_dr_o     (csr_dr),
		.gpio_i       ({dipsw_i, btn_i}),
		.gpio_o       (gpio_out),
		.gpio_irq_o   (gpio_irq_o),
		.hard_reset_o (hard_reset)
	);

	// UART activity, lines monitored only
	activity_led tx_led (
		.sys_clk (sys_clk),
		.reset_i (reset_i),
		.line_i  (uart_txd_i),
		.led_o   (tx_act)
	);

	activity_led rx_led (
		.sys_clk (sys_clk),
		.reset_i (reset_i),
		.line_i  (uart_rxd_i),
		.led_o   (rx_act)
	);

	// ---------------------------------------------------------------------
	// Pin mapping
	// ---------------------------------------------------------------------
	assign led_o    = {gpio_out[1:0], rx_act, tx_act};
	assign btnled_o = gpio_out[6:2];
	assign lcd_e_o  = gpio_out[7];
	assign lcd_rs_o = gpio_out[8];
	assign lcd_rw_o = gpio_out[9];
	assign lcd_d_o  = gpio_out[13:10];

endmodule

// File: verif/board_ctrl_tb.sv
// Directed testbench for board_ctrl_top, drives reset, bus, GPIO and UART pins and checks responses
`include "board_macros.svh"

module board_ctrl_tb;

	// Roughly 900 cycles of tests, generous margin
	localparam int          TIMEOUT_CYCLES = 6000;
	localparam int          ACK_LIMIT      = 10;
	localparam logic [31:0] ID_ASCII       = "X401";
	localparam logic [31:0] OUT_MASK       = (32'd1 << `GPIO_OUT_W) - 32'd1;
	localparam logic [3:0]  OTHER_BANK     = 4'd2;

	logic                 sys_clk;
	logic                 reset_i;
	logic                 rst_btn_n_i;
	csr_pkg::csr_adr_t    wb_adr_i;
	board_pkg::csr_word_t wb_dat_i;
	logic                 wb_cyc_i;
	logic                 wb_stb_i;
	logic                 wb_we_i;
	board_pkg::csr_word_t wb_dat_o;
	logic                 wb_ack_o;
	logic [4:0]           btn_i;
	logic [7:0]           dipsw_i;
	logic                 uart_rxd_i;
	logic                 uart_txd_i;
	logic [3:0]           led_o;
	logic [4:0]           btnled_o;
	logic                 lcd_e_o;
	logic                 lcd_rs_o;
	logic                 lcd_rw_o;
	logic [3:0]           lcd_d_o;
	logic                 gpio_irq_o;
	logic                 sys_rst_o;
	logic                 periph_rst_n_o;

	int          seed;
	int          error_count;
	int          cycle_cnt;
	logic [31:0] gpio_expect;

	board_ctrl_top dut (
		.sys_clk        (sys_clk),
		.reset_i        (reset_i),
		.rst_btn_n_i    (rst_btn_n_i),
		.wb_adr_i       (wb_adr_i),
		.wb_dat_i       (wb_dat_i),
		.wb_cyc_i       (wb_cyc_i),
		.wb_stb_i       (wb_stb_i),
		.wb_we_i        (wb_we_i),
		.wb_dat_o       (wb_dat_o),
		.wb_ack_o       (wb_ack_o),
		.btn_i          (btn_i),
		.dipsw_i        (dipsw_i),
		.uart_rxd_i     (uart_rxd_i),
		.uart_txd_i     (uart_txd_i),
		.led_o          (led_o),
		.btnled_o       (btnled_o),
		.lcd_e_o        (lcd_e_o),
		.lcd_rs_o       (lcd_rs_o),
		.lcd_rw_o       (lcd_rw_o),
		.lcd_d_o        (lcd_d_o),
		.gpio_irq_o     (gpio_irq_o),
		.sys_rst_o      (sys_rst_o),
		.periph_rst_n_o (periph_rst_n_o)
	);

	// 8 unit period
	always #4 sys_clk = ~sys_clk;

	// ---------------------------------------------------------------------
	// Helpers
	// ---------------------------------------------------------------------
	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_equal(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			error_count = error_count + 1;
			stop_with_failure($sformatf("error at time %0t: %s = 0x%0h, expected 0x%0h",
				$time, name, actual, expected));
		end
	endtask

	// Bank in the top 4 bits, register offset below
	function automatic csr_pkg::csr_adr_t csr_addr(input logic [3:0] bank,
		input logic [9:0] ofs);
		csr_addr = {bank, ofs};
	endfunction

	// Edge 0 samples the strobe, latency counted from there
	task automatic wait_ack(input int latency, input string kind);
		int n;
		n = 0;
		do begin
			@(negedge sys_clk);
			n++;
		end while (!wb_ack_o && n < ACK_LIMIT);
		if (!wb_ack_o)
			stop_with_failure({"bus acknowledge missing on ", kind});
		check_equal({kind, " ack latency"}, 32'(n - 1), 32'(latency));
	endtask

	task automatic wb_write(input csr_pkg::csr_adr_t adr, input board_pkg::csr_word_t data);
		wb_adr_i = adr;
		wb_dat_i = data;
		wb_we_i  = 1'b1;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wait_ack(2, "write");
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		// Strobe low for one cycle between transfers
		@(negedge sys_clk);
	endtask

	task automatic wb_read(input csr_pkg::csr_adr_t adr, output board_pkg::csr_word_t data);
		wb_adr_i = adr;
		wb_we_i  = 1'b0;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wait_ack(3, "read");
		data     = wb_dat_o;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		@(negedge sys_clk);
	endtask

	// Polls for system reset release, optionally watching the peripheral reset
	task automatic wait_reset_release(input int limit, input bit periph_hold);
		int n;
		n = 0;
		while (sys_rst_o && n < limit) begin
			@(negedge sys_clk);
			n++;
			if (periph_hold)
				check_equal("periph_rst_n_o during system reset", 32'(periph_rst_n_o), 32'd1);
		end
		if (sys_rst_o)
			stop_with_failure("system reset was not released in time");
	endtask

	// ---------------------------------------------------------------------
	// Tests
	// ---------------------------------------------------------------------
	task automatic test_reset_sequence();
		int cyc;
		int periph_cyc;
		int sys_cyc;
		int press_cyc;
		int i;
		reset_i = 1'b0;
		check_equal("sys_rst_o at reset release", 32'(sys_rst_o), 32'd1);
		check_equal("periph_rst_n_o at reset release", 32'(periph_rst_n_o), 32'd0);
		cyc        = 0;
		periph_cyc = 0;
		sys_cyc    = 0;
		while (sys_cyc == 0 && cyc < 100) begin
			@(negedge sys_clk);
			cyc++;
			if (periph_rst_n_o && periph_cyc == 0)
				periph_cyc = cyc;
			if (!sys_rst_o)
				sys_cyc = cyc;
		end
		$display("Reset release: peripheral at cycle %0d, system at cycle %0d",
			periph_cyc, sys_cyc);
		check_equal("periph_rst_n_o rise in cycles 16..18",
			32'(periph_cyc >= 16 && periph_cyc <= 18), 32'd1);
		check_equal("sys_rst_o fall in cycles 63..66",
			32'(sys_cyc >= 63 && sys_cyc <= 66), 32'd1);
		check_equal("periph before sys release", 32'(periph_cyc < sys_cyc), 32'd1);

		// 5 cycle button press
		rst_btn_n_i = 1'b0;
		press_cyc   = 0;
		for (i = 1; i <= 5; i++) begin
			@(negedge sys_clk);
			if (sys_rst_o && press_cyc == 0)
				press_cyc = i;
		end
		check_equal("sys_rst_o rise within 3 cycles of press",
			32'(press_cyc >= 1 && press_cyc <= 3), 32'd1);
		check_equal("periph_rst_n_o during press", 32'(periph_rst_n_o), 32'd0);
		rst_btn_n_i = 1'b1;
		wait_reset_release(100, 1'b0);
		check_equal("periph_rst_n_o after press", 32'(periph_rst_n_o), 32'd1);
	endtask

	task automatic test_id_and_gpio_out();
		board_pkg::csr_word_t rd;
		board_pkg::csr_word_t wr;
		wb_read(csr_addr(`SYSCTL_BANK, csr_pkg::REG_SYSTEM_ID), rd);
		check_equal("system id", rd, ID_ASCII);
		wr          = $random(seed);
		gpio_expect = wr & OUT_MASK;
		wb_write(csr_addr(`SYSCTL_BANK, csr_pkg::REG_GPIO_OUT), wr);
		wb_read(csr_addr(`SYSCTL_BANK, csr_pkg::REG_GPIO_OUT), rd);
		check_equal("gpio_out readback", rd, gpio_expect);
		// Pin mapping of the output word
		check_equal("led_o[3:2]", 32'(led_o[3:2]), 32'(gpio_expect[1:0]));
		check_equal("btnled_o", 32'(btnled_o), 32'(gpio_expect[6:2]));
		check_equal("lcd_e_o", 32'(lcd_e_o), 32'(gpio_expect[7]));
		check_equal("lcd_rs_o", 32'(lcd_rs_o), 32'(gpio_expect[8]));
		check_equal("lcd_rw_o", 32'(lcd_rw_o), 32'(gpio_expect[9]));
		check_equal("lcd_d_o", 32'(lcd_d_o), 32'(gpio_expect[13:10]));
	endtask

	task automatic test_gpio_in_irq();
		board_pkg::csr_word_t rd;
		logic [31:0]          gp;
		int                   n;
		gp      = $random(seed);
		btn_i   = gp[4:0];
		dipsw_i = gp[12:5];
		// Let the synchronizer settle
		repeat (4) @(negedge sys_clk);
		wb_read(csr_addr(`SYSCTL_BANK, csr_pkg::REG_GPIO_IN), rd);
		check_equal("gpio_in readback", rd, 32'({dipsw_i, btn_i}));

		// Enable button 0 only
		wb_write(csr_addr(`SYSCTL_BANK, csr_pkg::REG_IRQ_EN), 32'd1);
		check_equal("gpio_irq_o before toggle", 32'(gpio_irq_o), 32'd0);
		btn_i[0] = ~btn_i[0];
		n = 0;
		while (!gpio_irq_o && n < 4) begin
			@(negedge sys_clk);
			n++;
		end
		check_equal("gpio_irq_o after enabled toggle", 32'(gpio_irq_o), 32'd1);

		// Write 1 to clear
		wb_write(csr_addr(`SYSCTL_BANK, csr_pkg::REG_IRQ_PEND), 32'd1);
		check_equal("gpio_irq_o after clear", 32'(gpio_irq_o), 32'd0);

		// Disabled input, a dip switch
		dipsw_i[0] = ~dipsw_i[0];
		repeat (6) begin
			@(negedge sys_clk);
			check_equal("gpio_irq_o after disabled toggle", 32'(gpio_irq_o), 32'd0);
		end
	endtask

	task automatic test_bank_decode();
		board_pkg::csr_word_t rd;
		wb_write(csr_addr(OTHER_BANK, csr_pkg::REG_GPIO_OUT), ~gpio_expect);
		wb_read(csr_addr(`SYSCTL_BANK, csr_pkg::REG_GPIO_OUT), rd);
		check_equal("gpio_out after foreign bank write", rd, gpio_expect);
		wb_read(csr_addr(OTHER_BANK, csr_pkg::REG_GPIO_OUT), rd);
		check_equal("foreign bank read data", rd, 32'd0);
	endtask

	task automatic test_hard_reset();
		board_pkg::csr_word_t rd;
		int                   n;
		wb_write(csr_addr(`SYSCTL_BANK, csr_pkg::REG_HARD_RESET), 32'd1);
		n = 0;
		while (!sys_rst_o && n < 3) begin
			@(negedge sys_clk);
			n++;
		end
		check_equal("sys_rst_o after hard reset", 32'(sys_rst_o), 32'd1);
		wait_reset_release(100, 1'b1);
		wb_read(csr_addr(`SYSCTL_BANK, csr_pkg::REG_GPIO_OUT), rd);
		check_equal("gpio_out after hard reset", rd, 32'd0);
	endtask

	// Index 1 is the rx line, 0 the tx line
	task automatic test_activity_led(input logic [1:0] led_idx, input string name);
		int n;
		int lit_cyc;
		check_equal({name, " idle"}, 32'(led_o[led_idx]), 32'd0);
		if (led_idx == 2'd1)
			uart_rxd_i = 1'b0;
		else
			uart_txd_i = 1'b0;
		lit_cyc = 0;
		for (n = 1; n <= 4; n++) begin
			@(negedge sys_clk);
			if (led_o[led_idx] && lit_cyc == 0)
				lit_cyc = n;
		end
		check_equal({name, " lit within 2 cycles"},
			32'(lit_cyc >= 1 && lit_cyc <= 2), 32'd1);
		uart_rxd_i = 1'b1;
		uart_txd_i = 1'b1;
		repeat (250) @(negedge sys_clk);
		check_equal({name, " 250 cycles after line high"}, 32'(led_o[led_idx]), 32'd1);
		repeat (10) @(negedge sys_clk);
		check_equal({name, " 260 cycles after line high"}, 32'(led_o[led_idx]), 32'd0);
	endtask

	// ---------------------------------------------------------------------
	// Sequence and watchdog
	// ---------------------------------------------------------------------
	initial begin
		sys_clk     = 1'b0;
		seed        = 37;
		error_count = 0;
		gpio_expect = '0;
		reset_i     = 1'b1;
		rst_btn_n_i = 1'b1;
		wb_adr_i    = '0;
		wb_dat_i    = '0;
		wb_cyc_i    = 1'b0;
		wb_stb_i    = 1'b0;
		wb_we_i     = 1'b0;
		btn_i       = '0;
		dipsw_i     = '0;
		uart_rxd_i  = 1'b1;
		uart_txd_i  = 1'b1;
		repeat (10) @(negedge sys_clk);

		test_reset_sequence();
		test_id_and_gpio_out();
		test_gpio_in_irq();
		test_bank_decode();
		test_hard_reset();
		test_activity_led(2'd1, "led_o[1] rx");
		test_activity_led(2'd0, "led_o[0] tx");

		if (error_count == 0) begin
			$display("No errors");
			$finish;
		end else begin
			stop_with_failure("one or more checks failed");
		end
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge sys_clk);
			cycle_cnt++;
		end
		stop_with_failure("timeout, tests did not finish within the cycle limit");
	end

endmodule

// File: board_ctrl.f
+incdir+design
design/board_pkg.sv
design/csr_pkg.sv
design/reset_gen.sv
design/activity_led.sv
design/csr_bridge.sv
design/sysctl_gpio.sv
design/board_ctrl_top.sv
verif/board_ctrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= board_ctrl_tb
FLIST     ?= board_ctrl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: no pass message"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
